//--- tb/mem_adapter_stim.txt
# name stb we addr wdata rom_ret ram_ret rx_ret tx_full rx_full exp_ack exp_data exp_led exp_strobe
# Returns go out one cycle after the request, where ack, data and LED are also checked
rom_read         1 0 0123 00 5a 00 00 0 0 1 5a 0 rom
rom_top          1 0 3fff 00 a5 00 00 0 0 1 a5 0 rom
idle             0 0 0000 00 00 00 00 0 0 0 00 0 none
ram_write        1 1 4010 c3 00 ff 00 0 0 1 00 0 ram
ram_read         1 0 4010 00 00 3c 00 0 0 1 3c 0 ram
ram_top          1 0 9fff 00 00 99 00 0 0 1 99 0 ram
uart_rx          1 0 a001 00 00 00 7e 0 0 1 7e 0 rx
uart_tx          1 1 a001 41 00 00 ee 0 0 1 00 0 tx
uart_status_tx   1 0 a000 00 00 00 00 1 0 1 02 0 none
uart_status_rx   1 0 a000 00 00 00 00 0 1 1 01 0 none
led_on           1 1 a002 01 77 77 77 1 1 1 00 1 none
idle             0 0 0000 00 00 00 00 0 0 0 00 1 none
led_off          1 1 a002 fe 00 00 00 0 0 1 00 0 none
unmap_led_rd     1 0 a002 00 11 11 11 1 1 0 00 0 none
unmap_status_wr  1 1 a000 55 00 00 00 1 1 0 00 0 none
unmap_rd         1 0 b000 00 22 22 22 0 0 0 00 0 none
unmap_wr         1 1 b000 12 00 00 00 0 0 0 00 0 none
unmap_next       1 0 a003 00 33 33 33 0 0 0 00 0 none
b2b              1 0 0200 00 11 00 00 0 0 1 11 0 rom
b2b              1 0 5000 00 00 22 00 0 0 1 22 0 ram
b2b              1 0 a000 00 00 00 00 1 1 1 03 0 none
pipe             1 1 4020 77 00 44 00 0 0 1 00 0 ram
pipe             1 0 0001 00 66 00 00 0 0 1 66 0 rom
pipe             1 1 a001 5c 00 00 00 0 0 1 00 0 tx
pipe             1 1 a002 03 00 00 00 0 0 1 00 1 none

//--- all.f
hdl/mem_map_pkg.sv
hdl/bus_access_pkg.sv
hdl/bus_decode_stage.sv
hdl/bus_response_stage.sv
hdl/mem_adapter_top.sv
tb/tb_clock_gen.sv
tb/mem_adapter_checker.sv
tb/mem_adapter_properties.sv
tb/mem_adapter_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module mem_adapter_tb -Mdir obj_dir -f all.f
	./obj_dir/Vmem_adapter_tb | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- tb/mem_adapter_tb.sv
`timescale 1ns/1ps

module mem_adapter_tb;

    localparam int DATA_WIDTH  = mem_map_pkg::DATA_WIDTH_DEFAULT;
    localparam int ADDR_WIDTH  = mem_map_pkg::ADDR_WIDTH;
    localparam int DRIVE_DELAY = 1;
    localparam int MAX_GAP     = 3;
    localparam int WAIT_LIMIT  = 64;

    logic                                   clk;
    logic                                   reset_n;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [ADDR_WIDTH-1:0]                  wb_addr;
    logic [DATA_WIDTH-1:0]                  wb_wdata;
    logic                                   wb_ack;
    logic [DATA_WIDTH-1:0]                  wb_rdata;
    logic                                   rom_stb;
    logic [mem_map_pkg::ROM_ADDR_WIDTH-1:0] rom_addr;
    logic [DATA_WIDTH-1:0]                  rom_data;
    logic                                   ram_stb;
    logic                                   ram_wr;
    logic [mem_map_pkg::RAM_ADDR_WIDTH-1:0] ram_addr;
    logic [DATA_WIDTH-1:0]                  ram_wdata;
    logic [DATA_WIDTH-1:0]                  ram_rdata;
    logic                                   uart_rx_stb;
    logic [DATA_WIDTH-1:0]                  uart_rx_data;
    logic                                   uart_rx_full;
    logic                                   uart_tx_stb;
    logic [DATA_WIDTH-1:0]                  uart_tx_data;
    logic                                   uart_tx_full;
    logic                                   led;

    // Current stim line
    logic [127:0]            ln_name;
    logic                    ln_stb;
    logic                    ln_we;
    logic [ADDR_WIDTH-1:0]   ln_addr;
    logic [DATA_WIDTH-1:0]   ln_wdata;
    logic [DATA_WIDTH-1:0]   ln_rom;
    logic [DATA_WIDTH-1:0]   ln_ram;
    logic [DATA_WIDTH-1:0]   ln_rx;
    logic                    ln_tx_full;
    logic                    ln_rx_full;
    logic                    ln_exp_ack;
    logic [DATA_WIDTH-1:0]   ln_exp_data;
    logic                    ln_exp_led;
    string                   ln_strobe;

    // Return values wait one cycle behind their request
    logic [3*DATA_WIDTH+1:0] ret_next;
    logic                    last_led;

    logic                    chk_en;
    logic [127:0]            chk_name;
    logic [3:0]              chk_strobes;
    logic                    chk_ack;
    logic [DATA_WIDTH-1:0]   chk_data;
    logic                    chk_led;
    int                      checker_errors;
    logic                    checker_busy;
    int                      tb_errors;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(16)) i_tb_clock_gen (
        .o_clk (clk), .o_reset_n (reset_n)
    );

    mem_adapter_top #(.DATA_WIDTH(DATA_WIDTH)) i_mem_adapter_top (
        .i_clk (clk), .i_reset_n (reset_n),
        .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we),
        .i_wb_addr (wb_addr), .i_wb_data (wb_wdata), .o_wb_ack (wb_ack), .o_wb_data (wb_rdata),
        .o_rom_stb (rom_stb), .o_rom_addr (rom_addr), .i_rom_data (rom_data),
        .o_ram_stb (ram_stb), .o_ram_wr (ram_wr), .o_ram_addr (ram_addr),
        .o_ram_data (ram_wdata), .i_ram_data (ram_rdata),
        .o_uart_rx_stb (uart_rx_stb), .i_uart_rx_data (uart_rx_data),
        .i_uart_rx_full (uart_rx_full), .o_uart_tx_stb (uart_tx_stb),
        .o_uart_tx_data (uart_tx_data), .i_uart_tx_full (uart_tx_full),
        .o_completed_op_led (led)
    );

    mem_adapter_checker #(.DATA_WIDTH(DATA_WIDTH)) i_mem_adapter_checker (
        .i_clk (clk), .i_wb_we (wb_we), .i_wb_addr (wb_addr), .i_wb_wdata (wb_wdata),
        .i_rom_stb (rom_stb), .i_rom_addr (rom_addr),
        .i_ram_stb (ram_stb), .i_ram_wr (ram_wr), .i_ram_addr (ram_addr),
        .i_ram_data (ram_wdata), .i_uart_rx_stb (uart_rx_stb), .i_uart_tx_stb (uart_tx_stb),
        .i_uart_tx_data (uart_tx_data), .i_wb_ack (wb_ack), .i_wb_rdata (wb_rdata),
        .i_led (led), .i_chk_en (chk_en), .i_test_name (chk_name),
        .i_exp_strobes (chk_strobes), .i_exp_ack (chk_ack), .i_exp_data (chk_data),
        .i_exp_led (chk_led), .o_error_count (checker_errors), .o_busy (checker_busy)
    );

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        {rom_data, ram_rdata, uart_rx_data, uart_tx_full, uart_rx_full} = ret_next;
    endtask

    task automatic apply_line();
        step_cycle();
        {wb_cyc, wb_stb, wb_we} = {ln_stb, ln_stb, ln_we};
        wb_addr  = ln_addr;
        wb_wdata = ln_wdata;
        ret_next = {ln_rom, ln_ram, ln_rx, ln_tx_full, ln_rx_full};
        chk_en   = 1'b1;
        chk_name = ln_name;
        chk_strobes = {ln_strobe == "rom", ln_strobe == "ram",
                       ln_strobe == "rx", ln_strobe == "tx"};
        {chk_ack, chk_data, chk_led} = {ln_exp_ack, ln_exp_data, ln_exp_led};
        last_led = ln_exp_led;
    endtask

    // Idle bus cycle where the LED keeps its last value
    task automatic insert_idle(input logic check);
        step_cycle();
        {wb_cyc, wb_stb, wb_we, wb_addr, wb_wdata} = '0;
        ret_next = '0;
        chk_en   = check;
        chk_name = 128'("gap");
        {chk_strobes, chk_ack, chk_data, chk_led} =
            {4'b0000, 1'b0, {DATA_WIDTH{1'b0}}, last_led};
    endtask

    initial begin
        int    fd;
        int    fields;
        int    gap;
        int    waited;
        int    assert_errors;
        string line;
        logic  have_prev;
        logic [127:0] prev_name;

        {wb_cyc, wb_stb, wb_we, wb_addr, wb_wdata} = '0;
        {rom_data, ram_rdata, uart_rx_data, uart_tx_full, uart_rx_full} = '0;
        {chk_en, chk_name, chk_strobes, chk_ack, chk_data, chk_led} = '0;
        ret_next  = '0;
        last_led  = 1'b0;
        tb_errors = 0;
        have_prev = 1'b0;
        prev_name = '0;
        fd        = 0;
        void'($urandom(32'h76a35113));

        waited = 0;
        while (!reset_n && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!reset_n) begin
            $display("Timeout: reset was never released");
            tb_errors++;
        end else begin
            fd = $fopen("tb/mem_adapter_stim.txt", "r");
            if (fd == 0) begin
                $display("Could not open the stimulus file tb/mem_adapter_stim.txt");
                tb_errors++;
            end
        end

        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %s",
                                 ln_name, ln_stb, ln_we, ln_addr, ln_wdata, ln_rom, ln_ram,
                                 ln_rx, ln_tx_full, ln_rx_full, ln_exp_ack, ln_exp_data,
                                 ln_exp_led, ln_strobe);
                if (fields != 14) begin
                    $display("Malformed stimulus line: %s", line);
                    tb_errors++;
                end else begin
                    // Random idle gap only where a new test group starts
                    if (have_prev && ln_name != prev_name) begin
                        gap = $urandom % (MAX_GAP + 1);
                        repeat (gap) insert_idle(1'b1);
                    end
                    apply_line();
                    prev_name = ln_name;
                    have_prev = 1'b1;
                end
            end
        end

        if (fd != 0) begin
            $fclose(fd);
            insert_idle(1'b0);
            waited = 0;
            while (checker_busy && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (checker_busy) begin
                $display("Timeout: checker still had a response pending at the end");
                tb_errors++;
            end
        end

        assert_errors = i_mem_adapter_top.i_mem_adapter_properties.assert_failures;
        $display("Errors: %0d from checks, %0d from assertions, %0d from the testbench",
                 checker_errors, assert_errors, tb_errors);
        if (checker_errors == 0 && assert_errors == 0 && tb_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb/mem_adapter_properties.sv
`timescale 1ns/1ps

module mem_adapter_properties (
    input logic                                i_clk,
    input logic                                i_reset_n,
    input logic                                i_wb_cyc,
    input logic                                i_wb_stb,
    input logic                                i_wb_we,
    input logic [mem_map_pkg::ADDR_WIDTH-1:0]  i_wb_addr,
    input logic                                i_wb_ack,
    input logic                                i_rom_stb,
    input logic                                i_ram_stb,
    input logic                                i_uart_rx_stb,
    input logic                                i_uart_tx_stb
);

    logic mapped_req;
    logic any_stb;
    int   assert_failures = 0;

    // Memory regions, status reads, UART data port, LED writes
    assign mapped_req = i_wb_cyc && i_wb_stb &&
                        ((i_wb_addr < mem_map_pkg::RAM_ADDR_LIMIT) ||
                         (i_wb_addr == mem_map_pkg::UART_STATUS_ADDR && !i_wb_we) ||
                         (i_wb_addr == mem_map_pkg::UART_ACCESS_ADDR) ||
                         (i_wb_addr == mem_map_pkg::LED_ADDR && i_wb_we));
    assign any_stb = i_rom_stb || i_ram_stb || i_uart_rx_stb || i_uart_tx_stb;

    ack_follows_request: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        mapped_req |=> i_wb_ack)
        else begin
            $error("Mapped request was not acknowledged");
            assert_failures++;
        end

    // A new request in the ack cycle may legally keep ack high
    ack_single_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_wb_ack && !mapped_req |=> !i_wb_ack)
        else begin
            $error("Ack held longer than one cycle");
            assert_failures++;
        end

    one_strobe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $onehot0({i_rom_stb, i_ram_stb, i_uart_rx_stb, i_uart_tx_stb}))
        else begin
            $error("More than one target strobe high");
            assert_failures++;
        end

    strobe_needs_stb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        any_stb |-> i_wb_stb)
        else begin
            $error("Target strobe high without a bus strobe");
            assert_failures++;
        end

endmodule

bind mem_adapter_top mem_adapter_properties i_mem_adapter_properties (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_we       (i_wb_we),
    .i_wb_addr     (i_wb_addr),
    .i_wb_ack      (o_wb_ack),
    .i_rom_stb     (o_rom_stb),
    .i_ram_stb     (o_ram_stb),
    .i_uart_rx_stb (o_uart_rx_stb),
    .i_uart_tx_stb (o_uart_tx_stb)
);

//--- tb/mem_adapter_checker.sv
`timescale 1ns/1ps

module mem_adapter_checker #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_wb_we,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [DATA_WIDTH-1:0]                  i_wb_wdata,
    input  logic                                   i_rom_stb,
    input  logic [mem_map_pkg::ROM_ADDR_WIDTH-1:0] i_rom_addr,
    input  logic                                   i_ram_stb,
    input  logic                                   i_ram_wr,
    input  logic [mem_map_pkg::RAM_ADDR_WIDTH-1:0] i_ram_addr,
    input  logic [DATA_WIDTH-1:0]                  i_ram_data,
    input  logic                                   i_uart_rx_stb,
    input  logic                                   i_uart_tx_stb,
    input  logic [DATA_WIDTH-1:0]                  i_uart_tx_data,
    input  logic                                   i_wb_ack,
    input  logic [DATA_WIDTH-1:0]                  i_wb_rdata,
    input  logic                                   i_led,

    // Expectations for the request in the current cycle
    // Strobes are ordered rom, ram, rx, tx
    input  logic                                   i_chk_en,
    input  logic [127:0]                           i_test_name,
    input  logic [3:0]                             i_exp_strobes,
    input  logic                                   i_exp_ack,
    input  logic [DATA_WIDTH-1:0]                  i_exp_data,
    input  logic                                   i_exp_led,
    output int                                     o_error_count,
    output logic                                   o_busy
);

    localparam int ROM_AW = mem_map_pkg::ROM_ADDR_WIDTH;
    localparam int RAM_AW = mem_map_pkg::RAM_ADDR_WIDTH;

    int                                 error_count = 0;
    logic                               pend_valid = 1'b0;
    logic [127:0]                       pend_name;
    logic                               pend_ack;
    logic                               pend_led;
    logic [DATA_WIDTH-1:0]              pend_data;
    logic [mem_map_pkg::ADDR_WIDTH-1:0] ram_offset;

    assign o_error_count = error_count;
    assign o_busy        = pend_valid;

    // RAM sees addresses relative to the first RAM address
    assign ram_offset = i_wb_addr - mem_map_pkg::ROM_ADDR_LIMIT;

    task automatic compare_field(input logic [127:0] test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s: %0s expected %0h, actual %0h", test, field, expected, actual);
            error_count++;
        end
    endtask

    // Sampled mid-cycle, well clear of both the clock edge and the input drive
    always @(negedge i_clk) begin
        // Response to last cycle's request
        if (pend_valid) begin
            compare_field(pend_name, "o_wb_ack", 32'(pend_ack), 32'(i_wb_ack));
            if (pend_ack) begin
                compare_field(pend_name, "o_wb_data", 32'(pend_data), 32'(i_wb_rdata));
            end
            compare_field(pend_name, "o_completed_op_led", 32'(pend_led), 32'(i_led));
        end
        if (i_chk_en) begin
            compare_field(i_test_name, "o_rom_stb", 32'(i_exp_strobes[3]), 32'(i_rom_stb));
            compare_field(i_test_name, "o_ram_stb", 32'(i_exp_strobes[2]), 32'(i_ram_stb));
            compare_field(i_test_name, "o_uart_rx_stb", 32'(i_exp_strobes[1]),
                          32'(i_uart_rx_stb));
            compare_field(i_test_name, "o_uart_tx_stb", 32'(i_exp_strobes[0]),
                          32'(i_uart_tx_stb));
            if (i_exp_strobes[3]) begin
                compare_field(i_test_name, "o_rom_addr", 32'(i_wb_addr[ROM_AW-1:0]),
                              32'(i_rom_addr));
            end
            if (i_exp_strobes[2]) begin
                compare_field(i_test_name, "o_ram_addr", 32'(ram_offset[RAM_AW-1:0]),
                              32'(i_ram_addr));
                compare_field(i_test_name, "o_ram_wr", 32'(i_wb_we), 32'(i_ram_wr));
            end
            if (i_exp_strobes[2] && i_wb_we) begin
                compare_field(i_test_name, "o_ram_data", 32'(i_wb_wdata), 32'(i_ram_data));
            end
            if (i_exp_strobes[0]) begin
                compare_field(i_test_name, "o_uart_tx_data", 32'(i_wb_wdata),
                              32'(i_uart_tx_data));
            end
        end
        pend_valid = i_chk_en;
        pend_name  = i_test_name;
        pend_ack   = i_exp_ack;
        pend_data  = i_exp_data;
        pend_led   = i_exp_led;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset leaves 1 ns after an edge, like every other driven input
    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset_n = 1'b1;
    end

endmodule

//--- hdl/mem_adapter_top.sv
`timescale 1ns/1ps

module mem_adapter_top #(
    parameter int DATA_WIDTH = mem_map_pkg::DATA_WIDTH_DEFAULT
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset_n,

    // Z80-side bus
    input  logic                                   i_wb_cyc,
    input  logic                                   i_wb_stb,
    input  logic                                   i_wb_we,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [DATA_WIDTH-1:0]                  i_wb_data,
    output logic                                   o_wb_ack,
    output logic [DATA_WIDTH-1:0]                  o_wb_data,

    // ROM
    output logic                                   o_rom_stb,
    output logic [mem_map_pkg::ROM_ADDR_WIDTH-1:0] o_rom_addr,
    input  logic [DATA_WIDTH-1:0]                  i_rom_data,

    // RAM
    output logic                                   o_ram_stb,
    output logic                                   o_ram_wr,
    output logic [mem_map_pkg::RAM_ADDR_WIDTH-1:0] o_ram_addr,
    output logic [DATA_WIDTH-1:0]                  o_ram_data,
    input  logic [DATA_WIDTH-1:0]                  i_ram_data,

    // UART
    output logic                                   o_uart_rx_stb,
    input  logic [DATA_WIDTH-1:0]                  i_uart_rx_data,
    input  logic                                   i_uart_rx_full,
    output logic                                   o_uart_tx_stb,
    output logic [DATA_WIDTH-1:0]                  o_uart_tx_data,
    input  logic                                   i_uart_tx_full,

    output logic                                   o_completed_op_led
);

    // Access kind in flight between the two stages
    bus_access_pkg::access_kind_t acc_kind;

    bus_decode_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_bus_decode_stage (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_wb_cyc           (i_wb_cyc),
        .i_wb_stb           (i_wb_stb),
        .i_wb_we            (i_wb_we),
        .i_wb_addr          (i_wb_addr),
        .i_wb_data          (i_wb_data),
        .o_rom_stb          (o_rom_stb),
        .o_rom_addr         (o_rom_addr),
        .o_ram_stb          (o_ram_stb),
        .o_ram_wr           (o_ram_wr),
        .o_ram_addr         (o_ram_addr),
        .o_ram_data         (o_ram_data),
        .o_uart_rx_stb      (o_uart_rx_stb),
        .o_uart_tx_stb      (o_uart_tx_stb),
        .o_uart_tx_data     (o_uart_tx_data),
        .o_completed_op_led (o_completed_op_led),
        .o_acc_kind         (acc_kind)
    );

    bus_response_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_bus_response_stage (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_acc_kind     (acc_kind),
        .i_rom_data     (i_rom_data),
        .i_ram_data     (i_ram_data),
        .i_uart_rx_data (i_uart_rx_data),
        .i_uart_tx_full (i_uart_tx_full),
        .i_uart_rx_full (i_uart_rx_full),
        .o_wb_ack       (o_wb_ack),
        .o_wb_data      (o_wb_data)
    );

endmodule

//--- hdl/bus_response_stage.sv
`timescale 1ns/1ps

module bus_response_stage #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                         i_clk,
    input  logic                         i_reset_n,
    input  bus_access_pkg::access_kind_t i_acc_kind,

    // Return data from the targets, valid the cycle after their strobe
    input  logic [DATA_WIDTH-1:0]        i_rom_data,
    input  logic [DATA_WIDTH-1:0]        i_ram_data,
    input  logic [DATA_WIDTH-1:0]        i_uart_rx_data,
    input  logic                         i_uart_tx_full,
    input  logic                         i_uart_rx_full,

    output logic                         o_wb_ack,
    output logic [DATA_WIDTH-1:0]        o_wb_data
);

    logic [DATA_WIDTH-1:0] status_word;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [DATA_WIDTH-1:0] last_data;

    // Status word has the two FIFO full flags and zeros above them
    always_comb begin
        status_word = '0;
        status_word[bus_access_pkg::STATUS_RX_FULL_BIT] = i_uart_rx_full;
        status_word[bus_access_pkg::STATUS_TX_FULL_BIT] = i_uart_tx_full;
    end

    // Writes (RAM, UART TX, LED) return zero
    always_comb begin
        case (i_acc_kind)
            bus_access_pkg::ACC_ROM:         rd_data = i_rom_data;
            bus_access_pkg::ACC_RAM:         rd_data = i_ram_data;
            bus_access_pkg::ACC_UART_RX:     rd_data = i_uart_rx_data;
            bus_access_pkg::ACC_UART_STATUS: rd_data = status_word;
            default:                         rd_data = '0;
        endcase
    end

    // Every mapped access is acknowledged exactly once
    assign o_wb_ack = (i_acc_kind != bus_access_pkg::ACC_NONE);

    // Between acks the bus keeps showing the last returned word
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            last_data <= '0;
        end else if (o_wb_ack) begin
            last_data <= rd_data;
        end
    end

    assign o_wb_data = o_wb_ack ? rd_data : last_data;

endmodule

//--- hdl/bus_decode_stage.sv
`timescale 1ns/1ps

module bus_decode_stage #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset_n,

    // Request side of the bus
    input  logic                                   i_wb_cyc,
    input  logic                                   i_wb_stb,
    input  logic                                   i_wb_we,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [DATA_WIDTH-1:0]                  i_wb_data,

    // ROM
    output logic                                   o_rom_stb,
    output logic [mem_map_pkg::ROM_ADDR_WIDTH-1:0] o_rom_addr,

    // RAM
    output logic                                   o_ram_stb,
    output logic                                   o_ram_wr,
    output logic [mem_map_pkg::RAM_ADDR_WIDTH-1:0] o_ram_addr,
    output logic [DATA_WIDTH-1:0]                  o_ram_data,

    // UART FIFOs
    output logic                                   o_uart_rx_stb,
    output logic                                   o_uart_tx_stb,
    output logic [DATA_WIDTH-1:0]                  o_uart_tx_data,

    output logic                                   o_completed_op_led,
    output bus_access_pkg::access_kind_t           o_acc_kind
);

    logic                                 req_valid;
    bus_access_pkg::access_kind_t         kind;
    logic [mem_map_pkg::ADDR_WIDTH-1:0]   ram_offset;

    assign req_valid = i_wb_cyc && i_wb_stb;

    // Classify the request against the memory map
    // Status writes, LED reads and anything above 0xA002 stay ACC_NONE
    always_comb begin
        kind = bus_access_pkg::ACC_NONE;
        if (req_valid) begin
            if (i_wb_addr < mem_map_pkg::ROM_ADDR_LIMIT) begin
                kind = bus_access_pkg::ACC_ROM;
            end else if (i_wb_addr < mem_map_pkg::RAM_ADDR_LIMIT) begin
                kind = i_wb_we ? bus_access_pkg::ACC_RAM_WR : bus_access_pkg::ACC_RAM;
            end else if (i_wb_addr == mem_map_pkg::UART_STATUS_ADDR && !i_wb_we) begin
                kind = bus_access_pkg::ACC_UART_STATUS;
            end else if (i_wb_addr == mem_map_pkg::UART_ACCESS_ADDR) begin
                kind = i_wb_we ? bus_access_pkg::ACC_UART_TX : bus_access_pkg::ACC_UART_RX;
            end else if (i_wb_addr == mem_map_pkg::LED_ADDR && i_wb_we) begin
                kind = bus_access_pkg::ACC_LED;
            end
        end
    end

    // Strobes go out in the request cycle, at most one at a time
    assign o_rom_stb     = (kind == bus_access_pkg::ACC_ROM);
    assign o_ram_stb     = (kind == bus_access_pkg::ACC_RAM) || (kind == bus_access_pkg::ACC_RAM_WR);
    assign o_ram_wr      = (kind == bus_access_pkg::ACC_RAM_WR);
    assign o_uart_rx_stb = (kind == bus_access_pkg::ACC_UART_RX);
    assign o_uart_tx_stb = (kind == bus_access_pkg::ACC_UART_TX);

    // RAM is addressed relative to its base
    assign ram_offset = i_wb_addr - mem_map_pkg::ROM_ADDR_LIMIT;
    assign o_rom_addr = i_wb_addr[mem_map_pkg::ROM_ADDR_WIDTH-1:0];
    assign o_ram_addr = ram_offset[mem_map_pkg::RAM_ADDR_WIDTH-1:0];

    // Write data feeds both write targets, the strobes select which one takes it
    assign o_ram_data     = i_wb_data;
    assign o_uart_tx_data = i_wb_data;

    // Hand the access kind to the response stage
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_acc_kind <= bus_access_pkg::ACC_NONE;
        end else begin
            o_acc_kind <= kind;
        end
    end

    // Completion LED follows bit 0 of the last LED write
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_completed_op_led <= 1'b0;
        end else if (kind == bus_access_pkg::ACC_LED) begin
            o_completed_op_led <= i_wb_data[0];
        end
    end

endmodule

//--- hdl/bus_access_pkg.sv
package bus_access_pkg;

    // Kind of access carried from the decode stage to the response stage
    // RAM reads and writes are split so the response knows when to return zero
    typedef enum logic [2:0] {
        ACC_NONE        = 3'd0,
        ACC_ROM         = 3'd1,
        ACC_RAM         = 3'd2,
        ACC_RAM_WR      = 3'd3,
        ACC_UART_RX     = 3'd4,
        ACC_UART_TX     = 3'd5,
        ACC_UART_STATUS = 3'd6,
        ACC_LED         = 3'd7
    } access_kind_t;

    // UART status word layout, all other bits read as zero
    localparam int STATUS_RX_FULL_BIT = 0;
    localparam int STATUS_TX_FULL_BIT = 1;

endpackage

//--- hdl/mem_map_pkg.sv
package mem_map_pkg;

    // Bus widths
    localparam int DATA_WIDTH_DEFAULT = 8;
    localparam int ADDR_WIDTH         = 16;

    // ROM covers 16 KB, RAM needs 15 bits for its 24 KB
    localparam int ROM_ADDR_WIDTH = 14;
    localparam int RAM_ADDR_WIDTH = 15;

    // Region limits
    // ROM spans 0x0000 to 0x3FFF and RAM spans 0x4000 to 0x9FFF
    localparam logic [ADDR_WIDTH-1:0] ROM_ADDR_LIMIT = 16'h4000;
    localparam logic [ADDR_WIDTH-1:0] RAM_ADDR_LIMIT = 16'hA000;

    // Single-byte I/O registers just past the end of RAM
    localparam logic [ADDR_WIDTH-1:0] UART_STATUS_ADDR = 16'hA000;
    localparam logic [ADDR_WIDTH-1:0] UART_ACCESS_ADDR = 16'hA001;
    localparam logic [ADDR_WIDTH-1:0] LED_ADDR         = 16'hA002;

endpackage
